// ==== getir_pkg.sv ====
`default_nettype none

package getir_pkg;

localparam int PS_BIT     = 32;
localparam int BUYRUK_BIT = 32;
localparam int OPCODE_BIT = 7;
localparam int YER_BIT    = 4;

// Byte address of an instruction
typedef logic [PS_BIT-1:0]     ps_t;
typedef logic [BUYRUK_BIT-1:0] buyruk_t;
typedef logic [OPCODE_BIT-1:0] opcode_t;

// Free queue slot count seen by the first fetch stage
typedef logic [YER_BIT-1:0]    yer_t;

localparam opcode_t OPCODE_JAL  = 7'b1101111;
localparam ps_t     BUYRUK_ADIM = 32'd4;

// Largest count that fits in yer_t
localparam int YER_MAX = (1 << YER_BIT) - 1;

// Sign-extended J-type immediate
function automatic ps_t jal_hedef_ofset(input buyruk_t buyruk);
    ps_t ofset;
    ofset = {
        {11{buyruk[31]}},
        buyruk[31],
        buyruk[19:12],
        buyruk[20],
        buyruk[30:21],
        1'b0
    };
    return ofset;
endfunction

// Opcode field of an instruction word
function automatic opcode_t opcode_al(input buyruk_t buyruk);
    return buyruk[OPCODE_BIT-1:0];
endfunction

endpackage

`default_nettype wire

// ==== getir1.sv ====
`timescale 1ns/10ps
`default_nettype none

module getir1 #(
    parameter getir_pkg::ps_t BASLANGIC_PS = 32'h0000_1000
) (
    input  wire logic            clk_i,
    input  wire logic            arst_n_i,

    // Redirect from the selector
    input  wire logic            yonlendir_i,
    input  wire getir_pkg::ps_t  yonlendir_ps_i,

    // Slots still free in the second stage
    input  wire getir_pkg::yer_t bos_yer_i,

    // Instruction cache request
    output getir_pkg::ps_t       buyruk_istek_adres_o,
    output logic                 buyruk_istek_gecerli_o,
    input  wire logic            buyruk_istek_hazir_i,

    // To getir2
    output logic                 istek_kabul_o,
    output getir_pkg::ps_t       istek_ps_o
);

getir_pkg::ps_t ps_r;
logic           calisiyor_r;

// A redirect withdraws the pending request for the old path
assign buyruk_istek_gecerli_o = calisiyor_r && !yonlendir_i && (bos_yer_i != '0);
assign buyruk_istek_adres_o   = ps_r;

assign istek_kabul_o = buyruk_istek_gecerli_o && buyruk_istek_hazir_i;
assign istek_ps_o    = ps_r;

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        ps_r        <= BASLANGIC_PS;
        calisiyor_r <= 1'b0;
    end else begin
        calisiyor_r <= 1'b1;
        if (yonlendir_i) begin
            ps_r <= yonlendir_ps_i;
        end else if (istek_kabul_o) begin
            ps_r <= ps_r + getir_pkg::BUYRUK_ADIM;
        end
    end
end

// Pending request holds until taken or withdrawn by a redirect
a_istek_kararli: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (buyruk_istek_gecerli_o && !buyruk_istek_hazir_i)
    |=> yonlendir_i || (buyruk_istek_gecerli_o && $stable(buyruk_istek_adres_o))
) else $error("request address changed under back-pressure");

endmodule

`default_nettype wire

// ==== getir2.sv ====
`timescale 1ns/10ps
`default_nettype none

module getir2 #(
    parameter int KUYRUK_DERINLIK = 4
) (
    input  wire logic               clk_i,
    input  wire logic               arst_n_i,

    // Accepted requests from getir1
    input  wire logic               istek_kabul_i,
    input  wire getir_pkg::ps_t     istek_ps_i,

    // Instruction cache response
    input  wire getir_pkg::buyruk_t buyruk_yanit_veri_i,
    input  wire logic               buyruk_yanit_gecerli_i,
    output logic                    buyruk_yanit_hazir_o,

    input  wire logic               yonlendir_i,
    input  wire logic               bosalt_i,
    output getir_pkg::yer_t         bos_yer_o,

    // Static JAL prediction
    output getir_pkg::ps_t          tahmin_ps_o,
    output logic                    tahmin_gecerli_o,

    // Decode side
    output getir_pkg::buyruk_t      coz_buyruk_o,
    output getir_pkg::ps_t          coz_ps_o,
    output logic                    coz_atladi_o,
    output logic                    coz_gecerli_o,
    input  wire logic               coz_hazir_i
);

localparam int IW     = $clog2(KUYRUK_DERINLIK);
localparam int SW     = IW + 1;
// Room for several back-to-back flushes
localparam int ATIL_W = SW + 4;

// In-flight request addresses, oldest first
getir_pkg::ps_t     ucus_ps [KUYRUK_DERINLIK];
logic [IW-1:0]      ucus_yaz_r;
logic [IW-1:0]      ucus_oku_r;
logic [SW-1:0]      ucus_sayac_r;
logic [ATIL_W-1:0]  atilacak_r;
logic               tahmin_bekliyor_r;

// Response queue towards decode
getir_pkg::buyruk_t kuyruk_buyruk [KUYRUK_DERINLIK];
getir_pkg::ps_t     kuyruk_ps [KUYRUK_DERINLIK];
logic               kuyruk_atladi [KUYRUK_DERINLIK];
logic [IW-1:0]      kuyruk_yaz_r;
logic [IW-1:0]      kuyruk_oku_r;
logic [SW-1:0]      kuyruk_sayac_r;

logic               yanit_al;
logic               eski_yanit;
logic               ucus_it;
logic               ucus_cek;
logic               jal_mi;
logic               kuyruk_yaz;
logic               kuyruk_oku;
logic [SW-1:0]      serbest;
getir_pkg::ps_t     yanit_ps;

// Slot reservation keeps this high in normal operation
assign buyruk_yanit_hazir_o = (atilacak_r != '0) || tahmin_bekliyor_r
                            || (kuyruk_sayac_r != SW'(KUYRUK_DERINLIK));

assign yanit_al   = buyruk_yanit_gecerli_i && buyruk_yanit_hazir_o;
// Stale responses from before a flush come first
assign eski_yanit = yanit_al && (atilacak_r != '0);
assign ucus_cek   = yanit_al && (atilacak_r == '0);
assign ucus_it    = istek_kabul_i && !yonlendir_i;
assign yanit_ps   = ucus_ps[ucus_oku_r];

assign jal_mi     = getir_pkg::opcode_al(buyruk_yanit_veri_i) == getir_pkg::OPCODE_JAL;
assign kuyruk_yaz = ucus_cek && !tahmin_bekliyor_r && !yonlendir_i;
assign kuyruk_oku = coz_gecerli_o && coz_hazir_i;

assign tahmin_gecerli_o = kuyruk_yaz && jal_mi;
assign tahmin_ps_o      = yanit_ps + getir_pkg::jal_hedef_ofset(buyruk_yanit_veri_i);

assign serbest   = SW'(KUYRUK_DERINLIK) - kuyruk_sayac_r - ucus_sayac_r;
assign bos_yer_o = (serbest > getir_pkg::YER_MAX) ? getir_pkg::yer_t'(getir_pkg::YER_MAX)
                                                  : getir_pkg::yer_t'(serbest);

// A flush withdraws whatever the queue still holds
assign coz_gecerli_o = (kuyruk_sayac_r != '0) && !bosalt_i;
assign coz_buyruk_o  = kuyruk_buyruk[kuyruk_oku_r];
assign coz_ps_o      = kuyruk_ps[kuyruk_oku_r];
assign coz_atladi_o  = kuyruk_atladi[kuyruk_oku_r];

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        ucus_yaz_r        <= '0;
        ucus_oku_r        <= '0;
        ucus_sayac_r      <= '0;
        atilacak_r        <= '0;
        tahmin_bekliyor_r <= 1'b0;
    end else begin
        if (yonlendir_i) begin
            // Everything still in flight turns into responses to drop
            ucus_oku_r        <= ucus_yaz_r;
            ucus_sayac_r      <= '0;
            atilacak_r        <= atilacak_r - ATIL_W'(eski_yanit)
                               + ATIL_W'(ucus_sayac_r - SW'(ucus_cek));
            tahmin_bekliyor_r <= 1'b0;
        end else begin
            if (ucus_it) begin
                ucus_yaz_r <= ucus_yaz_r + 1'b1;
            end
            if (ucus_cek) begin
                ucus_oku_r <= ucus_oku_r + 1'b1;
            end
            ucus_sayac_r <= ucus_sayac_r + SW'(ucus_it) - SW'(ucus_cek);
            atilacak_r   <= atilacak_r - ATIL_W'(eski_yanit);
            if (tahmin_gecerli_o) begin
                tahmin_bekliyor_r <= 1'b1;
            end
        end
    end
end

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        kuyruk_yaz_r   <= '0;
        kuyruk_oku_r   <= '0;
        kuyruk_sayac_r <= '0;
    end else if (bosalt_i) begin
        kuyruk_yaz_r   <= '0;
        kuyruk_oku_r   <= '0;
        kuyruk_sayac_r <= '0;
    end else begin
        if (kuyruk_yaz) begin
            kuyruk_yaz_r <= kuyruk_yaz_r + 1'b1;
        end
        if (kuyruk_oku) begin
            kuyruk_oku_r <= kuyruk_oku_r + 1'b1;
        end
        kuyruk_sayac_r <= kuyruk_sayac_r + SW'(kuyruk_yaz) - SW'(kuyruk_oku);
    end
end

always_ff @(posedge clk_i) begin
    if (ucus_it) begin
        ucus_ps[ucus_yaz_r] <= istek_ps_i;
    end
    if (kuyruk_yaz) begin
        kuyruk_buyruk[kuyruk_yaz_r] <= buyruk_yanit_veri_i;
        kuyruk_ps[kuyruk_yaz_r]     <= yanit_ps;
        kuyruk_atladi[kuyruk_yaz_r] <= jal_mi;
    end
end

// Holds only if getir1 respects bos_yer
a_kuyruk_tasmaz: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (int'(kuyruk_sayac_r) + int'(ucus_sayac_r)) <= KUYRUK_DERINLIK
) else $error("response queue overflow");

endmodule

`default_nettype wire

// ==== ps_secici.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps_secici (
    input  wire logic           clk_i,
    input  wire logic           arst_n_i,

    input  wire getir_pkg::ps_t tuzak_ps_i,
    input  wire logic           tuzak_gecerli_i,
    input  wire getir_pkg::ps_t yurut_ps_i,
    input  wire logic           yurut_hatali_i,
    input  wire getir_pkg::ps_t tahmin_ps_i,
    input  wire logic           tahmin_gecerli_i,

    output logic                yonlendir_o,
    output getir_pkg::ps_t      yonlendir_ps_o,
    output logic                bosalt_o
);

typedef enum logic [1:0] {
    KAYNAK_YOK,
    KAYNAK_TUZAK,
    KAYNAK_YURUT,
    KAYNAK_TAHMIN
} kaynak_t;

kaynak_t        kaynak_r;
kaynak_t        kaynak_sec;
getir_pkg::ps_t ps_r;
getir_pkg::ps_t ps_sec;

// Trap beats misprediction, both cancel a same-cycle prediction
always_comb begin
    kaynak_sec = KAYNAK_YOK;
    ps_sec     = ps_r;
    if (tuzak_gecerli_i) begin
        kaynak_sec = KAYNAK_TUZAK;
        ps_sec     = tuzak_ps_i;
    end else if (yurut_hatali_i) begin
        kaynak_sec = KAYNAK_YURUT;
        ps_sec     = yurut_ps_i;
    end else if (tahmin_gecerli_i) begin
        kaynak_sec = KAYNAK_TAHMIN;
        ps_sec     = tahmin_ps_i;
    end
end

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        kaynak_r <= KAYNAK_YOK;
    end else begin
        kaynak_r <= kaynak_sec;
    end
end

always_ff @(posedge clk_i) begin
    ps_r <= ps_sec;
end

assign yonlendir_o    = kaynak_r != KAYNAK_YOK;
assign yonlendir_ps_o = ps_r;
// Only external sources empty the response queue
assign bosalt_o       = (kaynak_r == KAYNAK_TUZAK) || (kaynak_r == KAYNAK_YURUT);

endmodule

`default_nettype wire

// ==== getir_birimi.sv ====
`timescale 1ns/10ps
`default_nettype none

module getir_birimi #(
    parameter getir_pkg::ps_t BASLANGIC_PS    = 32'h0000_1000,
    parameter int             KUYRUK_DERINLIK = 4
) (
    input  wire logic               clk_i,
    input  wire logic               arst_n_i,

    // Instruction cache
    output getir_pkg::ps_t          buyruk_istek_adres_o,
    output logic                    buyruk_istek_gecerli_o,
    input  wire logic               buyruk_istek_hazir_i,
    input  wire getir_pkg::buyruk_t buyruk_yanit_veri_i,
    input  wire logic               buyruk_yanit_gecerli_i,
    output logic                    buyruk_yanit_hazir_o,

    // Decode
    output getir_pkg::buyruk_t      coz_buyruk_o,
    output getir_pkg::ps_t          coz_ps_o,
    output logic                    coz_atladi_o,
    output logic                    coz_gecerli_o,
    input  wire logic               coz_hazir_i,

    // External redirects
    input  wire getir_pkg::ps_t     tuzak_ps_i,
    input  wire logic               tuzak_gecerli_i,
    input  wire getir_pkg::ps_t     yurut_ps_i,
    input  wire logic               yurut_hatali_i
);

wire logic            istek_kabul;
wire getir_pkg::ps_t  istek_ps;
wire getir_pkg::yer_t bos_yer;
wire getir_pkg::ps_t  tahmin_ps;
wire logic            tahmin_gecerli;
wire logic            yonlendir;
wire getir_pkg::ps_t  yonlendir_ps;
wire logic            bosalt;

getir1 #(
    .BASLANGIC_PS               ( BASLANGIC_PS )
) i_getir1 (
    .clk_i                      ( clk_i ),
    .arst_n_i                   ( arst_n_i ),
    .yonlendir_i                ( yonlendir ),
    .yonlendir_ps_i             ( yonlendir_ps ),
    .bos_yer_i                  ( bos_yer ),
    .buyruk_istek_adres_o       ( buyruk_istek_adres_o ),
    .buyruk_istek_gecerli_o     ( buyruk_istek_gecerli_o ),
    .buyruk_istek_hazir_i       ( buyruk_istek_hazir_i ),
    .istek_kabul_o              ( istek_kabul ),
    .istek_ps_o                 ( istek_ps )
);

getir2 #(
    .KUYRUK_DERINLIK            ( KUYRUK_DERINLIK )
) i_getir2 (
    .clk_i                      ( clk_i ),
    .arst_n_i                   ( arst_n_i ),
    .istek_kabul_i              ( istek_kabul ),
    .istek_ps_i                 ( istek_ps ),
    .buyruk_yanit_veri_i        ( buyruk_yanit_veri_i ),
    .buyruk_yanit_gecerli_i     ( buyruk_yanit_gecerli_i ),
    .buyruk_yanit_hazir_o       ( buyruk_yanit_hazir_o ),
    .yonlendir_i                ( yonlendir ),
    .bosalt_i                   ( bosalt ),
    .bos_yer_o                  ( bos_yer ),
    .tahmin_ps_o                ( tahmin_ps ),
    .tahmin_gecerli_o           ( tahmin_gecerli ),
    .coz_buyruk_o               ( coz_buyruk_o ),
    .coz_ps_o                   ( coz_ps_o ),
    .coz_atladi_o               ( coz_atladi_o ),
    .coz_gecerli_o              ( coz_gecerli_o ),
    .coz_hazir_i                ( coz_hazir_i )
);

ps_secici i_ps_secici (
    .clk_i                      ( clk_i ),
    .arst_n_i                   ( arst_n_i ),
    .tuzak_ps_i                 ( tuzak_ps_i ),
    .tuzak_gecerli_i            ( tuzak_gecerli_i ),
    .yurut_ps_i                 ( yurut_ps_i ),
    .yurut_hatali_i             ( yurut_hatali_i ),
    .tahmin_ps_i                ( tahmin_ps ),
    .tahmin_gecerli_i           ( tahmin_gecerli ),
    .yonlendir_o                ( yonlendir ),
    .yonlendir_ps_o             ( yonlendir_ps ),
    .bosalt_o                   ( bosalt )
);

endmodule

`default_nettype wire

// ==== getir_denetleyici.sv ====
`timescale 1ns/10ps
`default_nettype none

module getir_denetleyici #(
    parameter getir_pkg::ps_t BASLANGIC_PS = 32'h0000_1000
) (
    input  wire logic               clk_i,
    input  wire logic               arst_n_i,
    input  wire getir_pkg::buyruk_t coz_buyruk_i,
    input  wire getir_pkg::ps_t     coz_ps_i,
    input  wire logic               coz_atladi_i,
    input  wire logic               coz_gecerli_i,
    input  wire logic               coz_hazir_i,
    input  wire getir_pkg::ps_t     tuzak_ps_i,
    input  wire logic               tuzak_gecerli_i,
    input  wire getir_pkg::ps_t     yurut_ps_i,
    input  wire logic               yurut_hatali_i,
    output int                      hata_sayisi_o
);

getir_pkg::ps_t beklenen;
logic           jal;

always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        beklenen      = BASLANGIC_PS;
        hata_sayisi_o = 0;
    end else begin
        if (coz_gecerli_i && coz_hazir_i) begin
            jal = coz_buyruk_i[6:0] == getir_pkg::OPCODE_JAL;
            if (coz_ps_i !== beklenen) begin
                $display("ERR %0t: delivered address %h, expected %h",
                         $time, coz_ps_i, beklenen);
                hata_sayisi_o++;
            end
            if (coz_atladi_i !== jal) begin
                $display("ERR %0t: taken flag %b at %h", $time, coz_atladi_i, coz_ps_i);
                hata_sayisi_o++;
            end
            // ADDI words carry their own address
            if (!jal && coz_buyruk_i[31:7] !== (coz_ps_i[26:2] ^ {coz_ps_i[31:27], 20'h0})) begin
                $display("ERR %0t: word %h does not belong to %h",
                         $time, coz_buyruk_i, coz_ps_i);
                hata_sayisi_o++;
            end
            if (jal) begin
                beklenen = coz_ps_i + getir_pkg::jal_hedef_ofset(coz_buyruk_i);
            end else begin
                beklenen = coz_ps_i + getir_pkg::BUYRUK_ADIM;
            end
        end
        // Trap wins over misprediction
        if (tuzak_gecerli_i) begin
            beklenen = tuzak_ps_i;
        end else if (yurut_hatali_i) begin
            beklenen = yurut_ps_i;
        end
    end
end

endmodule

`default_nettype wire

// ==== tb_getir_birimi.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_getir_birimi;

localparam getir_pkg::ps_t BASLANGIC_PS = 32'h0000_1000;
localparam int SATIR = 11;

logic               clk_i;
logic               arst_n_i;
getir_pkg::ps_t     buyruk_istek_adres_o;
logic               buyruk_istek_gecerli_o;
logic               buyruk_istek_hazir_i;
getir_pkg::buyruk_t buyruk_yanit_veri_i;
logic               buyruk_yanit_gecerli_i;
logic               buyruk_yanit_hazir_o;
getir_pkg::buyruk_t coz_buyruk_o;
getir_pkg::ps_t     coz_ps_o;
logic               coz_atladi_o;
logic               coz_gecerli_o;
logic               coz_hazir_i;
getir_pkg::ps_t     tuzak_ps_i;
logic               tuzak_gecerli_i;
getir_pkg::ps_t     yurut_ps_i;
logic               yurut_hatali_i;

int                 denetci_hata;
int                 tablo_hata;
integer             seed;

// Stimulus table, kind 0 none, 1 trap, 2 misprediction, 3 both
int                 bekle [SATIR];
logic [1:0]         tur [SATIR];
getir_pkg::ps_t     adres [SATIR];
int                 durak [SATIR];
getir_pkg::ps_t     sonraki [SATIR];

getir_pkg::ps_t     bekleyen [$];
int                 gecikme;

getir_birimi #(
    .BASLANGIC_PS           ( BASLANGIC_PS ),
    .KUYRUK_DERINLIK        ( 4 )
) i_dut (
    .clk_i                  ( clk_i ),
    .arst_n_i               ( arst_n_i ),
    .buyruk_istek_adres_o   ( buyruk_istek_adres_o ),
    .buyruk_istek_gecerli_o ( buyruk_istek_gecerli_o ),
    .buyruk_istek_hazir_i   ( buyruk_istek_hazir_i ),
    .buyruk_yanit_veri_i    ( buyruk_yanit_veri_i ),
    .buyruk_yanit_gecerli_i ( buyruk_yanit_gecerli_i ),
    .buyruk_yanit_hazir_o   ( buyruk_yanit_hazir_o ),
    .coz_buyruk_o           ( coz_buyruk_o ),
    .coz_ps_o               ( coz_ps_o ),
    .coz_atladi_o           ( coz_atladi_o ),
    .coz_gecerli_o          ( coz_gecerli_o ),
    .coz_hazir_i            ( coz_hazir_i ),
    .tuzak_ps_i             ( tuzak_ps_i ),
    .tuzak_gecerli_i        ( tuzak_gecerli_i ),
    .yurut_ps_i             ( yurut_ps_i ),
    .yurut_hatali_i         ( yurut_hatali_i )
);

getir_denetleyici #(
    .BASLANGIC_PS           ( BASLANGIC_PS )
) i_denetleyici (
    .clk_i                  ( clk_i ),
    .arst_n_i               ( arst_n_i ),
    .coz_buyruk_i           ( coz_buyruk_o ),
    .coz_ps_i               ( coz_ps_o ),
    .coz_atladi_i           ( coz_atladi_o ),
    .coz_gecerli_i          ( coz_gecerli_o ),
    .coz_hazir_i            ( coz_hazir_i ),
    .tuzak_ps_i             ( tuzak_ps_i ),
    .tuzak_gecerli_i        ( tuzak_gecerli_i ),
    .yurut_ps_i             ( yurut_ps_i ),
    .yurut_hatali_i         ( yurut_hatali_i ),
    .hata_sayisi_o          ( denetci_hata )
);

always #4 clk_i = ~clk_i;

// JAL with rd = x1 and the given byte offset
function automatic getir_pkg::buyruk_t encode_jal(input logic [20:0] ofs);
    return {ofs[20], ofs[10:1], ofs[11], ofs[19:12], 5'd1, getir_pkg::OPCODE_JAL};
endfunction

// Program image, every other word is an ADDI tagged with its address
function automatic getir_pkg::buyruk_t program_word(input getir_pkg::ps_t a);
    if (a == 32'h1020) begin
        return encode_jal(21'h40);
    end else if (a == 32'h3008) begin
        return encode_jal(21'h100);
    end else if (a == 32'h5010) begin
        return encode_jal(-21'sd16);
    end
    return {a[26:2] ^ {a[31:27], 20'h0}, 7'b0010011};
endfunction

// In-order cache model with random latency
always @(posedge clk_i) begin
    buyruk_istek_hazir_i <= ($random(seed) & 3) != 0;
    if (buyruk_istek_gecerli_o && buyruk_istek_hazir_i) begin
        bekleyen.push_back(buyruk_istek_adres_o);
    end
    if (buyruk_yanit_gecerli_i && buyruk_yanit_hazir_o) begin
        buyruk_yanit_gecerli_i <= 1'b0;
        gecikme <= $random(seed) & 3;
    end else if (!buyruk_yanit_gecerli_i) begin
        if (gecikme > 0) begin
            gecikme <= gecikme - 1;
        end else if (bekleyen.size() > 0) begin
            buyruk_yanit_veri_i    <= program_word(bekleyen.pop_front());
            buyruk_yanit_gecerli_i <= 1'b1;
        end
    end
end

task automatic set_row(input int i, input int n, input logic [1:0] k,
                       input getir_pkg::ps_t a, input int s, input getir_pkg::ps_t e);
    bekle[i]   = n;
    tur[i]     = k;
    adres[i]   = a;
    durak[i]   = s;
    sonraki[i] = e;
endtask

task automatic wait_deliveries(input int n);
    int sayac;
    sayac = 0;
    while (sayac < n) begin
        @(posedge clk_i);
        if (coz_gecerli_o && coz_hazir_i) begin
            sayac++;
        end
    end
endtask

// Stall decode and fire the redirect inside the stall
task automatic stall_and_redirect(input int i);
    int tut;
    tut = durak[i];
    if (tur[i] != 2'd0 && tut < 2) begin
        tut = 2;
    end
    if (tut > 0) begin
        coz_hazir_i <= 1'b0;
        for (int k = 0; k < tut; k++) begin
            @(posedge clk_i);
            if (k == 0) begin
                tuzak_gecerli_i <= tur[i][0];
                tuzak_ps_i      <= adres[i];
                yurut_hatali_i  <= tur[i][1];
                yurut_ps_i      <= (tur[i] == 2'd3) ? adres[i] + 32'h1000 : adres[i];
            end else if (k == 1) begin
                tuzak_gecerli_i <= 1'b0;
                yurut_hatali_i  <= 1'b0;
            end
        end
        coz_hazir_i <= 1'b1;
    end
endtask

initial begin
    seed = 89575;
    clk_i = 1'b0;
    arst_n_i = 1'b0;
    buyruk_istek_hazir_i = 1'b0;
    buyruk_yanit_veri_i = '0;
    buyruk_yanit_gecerli_i = 1'b0;
    coz_hazir_i = 1'b1;
    tuzak_ps_i = '0;
    tuzak_gecerli_i = 1'b0;
    yurut_ps_i = '0;
    yurut_hatali_i = 1'b0;
    gecikme = 0;
    tablo_hata = 0;

    set_row(0,  0, 2'd0, 32'h0,    0,  32'h1000);
    set_row(1,  8, 2'd0, 32'h0,    0,  32'h1060);
    set_row(2,  3, 2'd1, 32'h3000, 5,  32'h3000);
    set_row(3,  2, 2'd0, 32'h0,    20, 32'h3108);
    set_row(4,  4, 2'd2, 32'h4000, 3,  32'h4000);
    set_row(5,  2, 2'd3, 32'h5000, 0,  32'h5000);
    set_row(6,  6, 2'd0, 32'h0,    30, 32'h5008);
    set_row(7,  10, 2'd2, 32'h1000, 0, 32'h1000);
    set_row(8,  20, 2'd0, 32'h0,    2, 32'h1090);
    set_row(9,  0, 2'd1, 32'h7000, 4,  32'h7000);
    set_row(10, 40, 2'd0, 32'h0,   10, 32'h70A4);

    repeat (2) @(posedge clk_i);
    if (buyruk_istek_gecerli_o || coz_gecerli_o || !buyruk_yanit_hazir_o
        || buyruk_istek_adres_o !== BASLANGIC_PS) begin
        $display("ERR %0t: outputs not in their reset state", $time);
        tablo_hata++;
    end
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;

    for (int i = 0; i < SATIR; i++) begin
        wait_deliveries(bekle[i]);
        stall_and_redirect(i);
        wait_deliveries(1);
        if (coz_ps_o !== sonraki[i]) begin
            $display("ERR %0t: row %0d delivered %h, expected %h",
                     $time, i, coz_ps_o, sonraki[i]);
            tablo_hata++;
        end
    end

    repeat (4) @(posedge clk_i);
    $display("Errors: checker %0d, table %0d", denetci_hata, tablo_hata);
    if (denetci_hata == 0 && tablo_hata == 0) begin
        $display("All tests passed");
    end else begin
        $display("Some tests failed");
    end
    $finish;
end

initial begin
    #(SATIR * 200 * 8);
    $display("Timeout: the decode stream stopped before the table was done");
    $display("Some tests failed");
    $finish;
end

endmodule

`default_nettype wire

// ==== getir_birimi.f ====
getir_pkg.sv
getir1.sv
getir2.sv
ps_secici.sv
getir_birimi.sv
getir_denetleyici.sv
tb_getir_birimi.sv

// ==== calistir.sh ====
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_getir_birimi \
    -f getir_birimi.f \
    -o sim_getir_birimi
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

cikti=$(./obj_dir/sim_getir_birimi)
durum=$?
echo "$cikti"
if [ $durum -ne 0 ]; then
    echo "Simulation exited with status $durum"
    exit 1
fi

if echo "$cikti" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
